// File: include/vdec_defines.svh
// Vector decode constants
`ifndef VDEC_DEFINES_SVH
`define VDEC_DEFINES_SVH

`define VDEC_ILEN 32
`define VDEC_OPCODE_OPV 7'h57

`define VDEC_F3_OPIVV 3'd0
`define VDEC_F3_OPFVV 3'd1
`define VDEC_F3_OPMVV 3'd2
`define VDEC_F3_OPIVI 3'd3
`define VDEC_F3_OPIVX 3'd4
`define VDEC_F3_OPFVF 3'd5
`define VDEC_F3_OPMVX 3'd6
`define VDEC_F3_OPCFG 3'd7

`endif

// File: hw/vdec_pkg.sv
// Vector decode types
package vdec_pkg;

    // OPI funct6 codes
    typedef enum logic [5:0] {
        VADD      = 6'b000000, VSUB       = 6'b000010, VRSUB    = 6'b000011,
        VMINU     = 6'b000100, VMIN       = 6'b000101, VMAXU    = 6'b000110,
        VMAX      = 6'b000111, VAND       = 6'b001001, VOR      = 6'b001010,
        VXOR      = 6'b001011, VRGATHER   = 6'b001100, VSLIDEUP = 6'b001110,
        VSLIDEDOWN = 6'b001111, VADC      = 6'b010000, VMADC    = 6'b010001,
        VSBC      = 6'b010010, VMSBC      = 6'b010011, VMERGE   = 6'b010111,
        VMSEQ     = 6'b011000, VMSNE      = 6'b011001, VMSLTU   = 6'b011010,
        VMSLT     = 6'b011011, VMSLEU     = 6'b011100, VMSLE    = 6'b011101,
        VMSGTU    = 6'b011110, VMSGT      = 6'b011111, VSADDU   = 6'b100000,
        VSADD     = 6'b100001, VSSUBU     = 6'b100010, VSSUB    = 6'b100011,
        VSLL      = 6'b100101, VSMUL      = 6'b100111, VSRL     = 6'b101000,
        VSRA      = 6'b101001, VSSRL      = 6'b101010, VSSRA    = 6'b101011,
        VNSRL     = 6'b101100, VNSRA      = 6'b101101, VNCLIPU  = 6'b101110,
        VNCLIP    = 6'b101111, VWREDSUMU  = 6'b110000, VWREDSUM = 6'b110001
    } vopi_t;

    // Supported subset of the OPM funct6 codes
    typedef enum logic [5:0] {
        VREDSUM  = 6'h00, VREDAND  = 6'h01, VREDOR  = 6'h02, VREDXOR = 6'h03,
        VREDMINU = 6'h04, VREDMIN  = 6'h05, VREDMAXU = 6'h06, VREDMAX = 6'h07,
        VMANDN   = 6'h18, VMAND    = 6'h19, VMOR    = 6'h1a, VMXOR   = 6'h1b,
        VMORN    = 6'h1c, VMNAND   = 6'h1d, VMNOR   = 6'h1e, VMXNOR  = 6'h1f,
        VMULHU   = 6'h24, VMUL     = 6'h25, VMULH   = 6'h27
    } vopm_t;

    typedef logic [2:0] vfunct3_t;

    typedef enum logic [1:0] {SEW8, SEW16, SEW32, SEW64} vsew_t;

    typedef enum logic [2:0] {
        VFU_ALU, VFU_PRM, VFU_RED, VFU_MSK, VFU_MUL, VFU_PASS_VS2
    } vfu_t;

    typedef enum logic [4:0] {
        VALU_ADD, VALU_SUB, VALU_RSB, VALU_ADC, VALU_SBC,
        VALU_VMADC, VALU_VMADC_NO_C, VALU_VMSBC, VALU_VMSBC_NO_B,
        VALU_MERGE, VALU_INT_MOVE, VALU_MIN, VALU_MAX,
        VALU_AND, VALU_OR, VALU_XOR,
        VALU_SEQ, VALU_SNE, VALU_SLT, VALU_SLE, VALU_SGT,
        VALU_SLL, VALU_SRL, VALU_SRA
    } valuop_t;

    typedef enum logic [2:0] {
        VMSK_AND, VMSK_NAND, VMSK_ANDN, VMSK_OR,
        VMSK_NOR, VMSK_ORN, VMSK_XOR, VMSK_XNOR
    } vmaskop_t;

    typedef enum logic [1:0] {VPRM_CPS, VPRM_GTR, VPRM_SLU, VPRM_SLD} vpermop_t;

    typedef enum logic [1:0] {VMUL_LO, VMUL_HI, VMUL_HIU} vmulop_t;

    // Control record for the execute stage
    typedef struct packed {
        vfu_t     vfu;
        valuop_t  valuop;
        vmaskop_t vmaskop;
        vpermop_t vpermop;
        vmulop_t  vmulop;
        logic     vopunsigned;
    } vexec_t;

    typedef struct packed {
        logic [5:0] funct6;
        logic       vm;
        logic [4:0] vs2;
        logic [4:0] vs1;
        vfunct3_t   funct3;
        logic [4:0] vd;
        logic [6:0] opcode;
    } varith_t;

    typedef struct packed {
        logic [4:0] upper;  // vma, vta and reserved bits
        logic [2:0] vsew;
        logic [2:0] vlmul;
    } vzimm_t;

    typedef struct packed {
        logic       cfg_kind;   // Zero for vsetvli
        vzimm_t     zimm;
        logic [4:0] rs1;
        vfunct3_t   funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } vcfg_t;

    // One instruction word, arithmetic or configuration layout
    typedef union packed {
        varith_t arith;
        vcfg_t   cfg;
    } vinstr_u;

endpackage

// File: hw/vdec_result_if.sv
// Decoder result bundle
`timescale 1ns/1ps

interface vdec_result_if;
    vdec_pkg::vexec_t exec;
    logic             valid;
    logic             disable_mask;
    vdec_pkg::vsew_t  veew_dest;

    modport producer (
        output exec,
        output valid,
        output disable_mask,
        output veew_dest
    );

    modport consumer (
        input exec,
        input valid,
        input disable_mask,
        input veew_dest
    );
endinterface

// File: hw/vdec_opi_decode.sv
// OPI funct6 decoder
`timescale 1ns/1ps
`include "vdec_defines.svh"

module vdec_opi_decode (
    input  vdec_pkg::vopi_t    vopi,
    input  vdec_pkg::vfunct3_t vfunct3,
    input  logic               vm_bit,
    input  vdec_pkg::vsew_t    vsew,
    vdec_result_if.producer    res
);

    vdec_pkg::vexec_t exec;
    logic             valid;
    logic             disable_mask;
    vdec_pkg::vsew_t  veew_dest;

    always_comb begin
        valid = 1'b1;
        exec  = '0;         // ALU, ADD and unit defaults
        exec.vfu = vdec_pkg::VFU_ALU;

        case (vopi)
            vdec_pkg::VADD, vdec_pkg::VSADDU, vdec_pkg::VSADD: exec.valuop = vdec_pkg::VALU_ADD;
            vdec_pkg::VSUB, vdec_pkg::VSSUBU, vdec_pkg::VSSUB: exec.valuop = vdec_pkg::VALU_SUB;
            vdec_pkg::VRSUB:                  exec.valuop = vdec_pkg::VALU_RSB;
            vdec_pkg::VMINU, vdec_pkg::VMIN:  exec.valuop = vdec_pkg::VALU_MIN;
            vdec_pkg::VMAXU, vdec_pkg::VMAX:  exec.valuop = vdec_pkg::VALU_MAX;
            vdec_pkg::VAND:                   exec.valuop = vdec_pkg::VALU_AND;
            vdec_pkg::VOR:                    exec.valuop = vdec_pkg::VALU_OR;
            vdec_pkg::VXOR:                   exec.valuop = vdec_pkg::VALU_XOR;
            vdec_pkg::VRGATHER: begin
                exec.vfu     = vdec_pkg::VFU_PRM;
                exec.vpermop = vdec_pkg::VPRM_GTR;
            end
            vdec_pkg::VSLIDEUP: begin
                exec.vfu     = vdec_pkg::VFU_PRM;
                exec.vpermop = vdec_pkg::VPRM_SLU;
            end
            vdec_pkg::VSLIDEDOWN: begin
                exec.vfu     = vdec_pkg::VFU_PRM;
                exec.vpermop = vdec_pkg::VPRM_SLD;
            end
            vdec_pkg::VADC:   exec.valuop = vdec_pkg::VALU_ADC;
            vdec_pkg::VSBC:   exec.valuop = vdec_pkg::VALU_SBC;
            vdec_pkg::VMADC:  exec.valuop = vm_bit ? vdec_pkg::VALU_VMADC
                                                   : vdec_pkg::VALU_VMADC_NO_C;
            vdec_pkg::VMSBC:  exec.valuop = vm_bit ? vdec_pkg::VALU_VMSBC
                                                   : vdec_pkg::VALU_VMSBC_NO_B;
            vdec_pkg::VMERGE: exec.valuop = vm_bit ? vdec_pkg::VALU_INT_MOVE
                                                   : vdec_pkg::VALU_MERGE;
            vdec_pkg::VMSEQ:  exec.valuop = vdec_pkg::VALU_SEQ;
            vdec_pkg::VMSNE:  exec.valuop = vdec_pkg::VALU_SNE;
            vdec_pkg::VMSLTU, vdec_pkg::VMSLT: exec.valuop = vdec_pkg::VALU_SLT;
            vdec_pkg::VMSLEU, vdec_pkg::VMSLE: exec.valuop = vdec_pkg::VALU_SLE;
            vdec_pkg::VMSGTU, vdec_pkg::VMSGT: exec.valuop = vdec_pkg::VALU_SGT;
            vdec_pkg::VSLL:   exec.valuop = vdec_pkg::VALU_SLL;
            vdec_pkg::VSMUL:  exec.vfu = vdec_pkg::VFU_PASS_VS2;   // Treated as whole-register move
            vdec_pkg::VSRL, vdec_pkg::VSSRL, vdec_pkg::VNSRL: exec.valuop = vdec_pkg::VALU_SRL;
            vdec_pkg::VSRA, vdec_pkg::VSSRA, vdec_pkg::VNSRA: exec.valuop = vdec_pkg::VALU_SRA;
            vdec_pkg::VWREDSUMU, vdec_pkg::VWREDSUM: exec.vfu = vdec_pkg::VFU_RED;
            default: valid = 1'b0;  // Clips and unassigned codes
        endcase

        case (vopi)
            vdec_pkg::VMINU, vdec_pkg::VMAXU, vdec_pkg::VMSLTU, vdec_pkg::VMSLEU,
            vdec_pkg::VMSGTU, vdec_pkg::VSADDU, vdec_pkg::VSSUBU, vdec_pkg::VSRL,
            vdec_pkg::VNSRL, vdec_pkg::VWREDSUMU: exec.vopunsigned = 1'b1;
            default: ;
        endcase

        // Carry-in and merge forms consume v0 as data
        case (vopi)
            vdec_pkg::VADC, vdec_pkg::VMADC, vdec_pkg::VSBC, vdec_pkg::VMSBC,
            vdec_pkg::VMERGE: disable_mask = 1'b1;
            default:          disable_mask = 1'b0;
        endcase

        // Mask-producing ops write one bit per element
        case (vopi)
            vdec_pkg::VMADC, vdec_pkg::VMSBC, vdec_pkg::VMSEQ, vdec_pkg::VMSNE,
            vdec_pkg::VMSLTU, vdec_pkg::VMSLT, vdec_pkg::VMSLEU, vdec_pkg::VMSLE,
            vdec_pkg::VMSGTU, vdec_pkg::VMSGT: veew_dest = vdec_pkg::SEW8;
            default:                           veew_dest = vsew;
        endcase

        // These funct3 values belong to the OPM and OPF spaces
        case (vfunct3)
            `VDEC_F3_OPFVV, `VDEC_F3_OPMVV, `VDEC_F3_OPFVF, `VDEC_F3_OPMVX: valid = 1'b0;
            default: ;
        endcase
    end

    assign res.exec         = exec;
    assign res.valid        = valid;
    assign res.disable_mask = disable_mask;
    assign res.veew_dest    = veew_dest;

endmodule

// File: hw/vdec_opm_decode.sv
// OPM funct6 decoder
`timescale 1ns/1ps

module vdec_opm_decode (
    input  vdec_pkg::vopm_t    vopm,
    input  logic               vm_bit,
    input  vdec_pkg::vsew_t    vsew,
    vdec_result_if.producer    res
);

    vdec_pkg::vexec_t exec;
    logic             valid;
    logic             disable_mask;
    vdec_pkg::vsew_t  veew_dest;

    always_comb begin
        exec         = '0;
        exec.vfu     = vdec_pkg::VFU_RED;
        valid        = 1'b1;
        disable_mask = 1'b0;
        veew_dest    = vsew;

        case (vopm)
            vdec_pkg::VREDSUM:  exec.valuop = vdec_pkg::VALU_ADD;
            vdec_pkg::VREDAND:  exec.valuop = vdec_pkg::VALU_AND;
            vdec_pkg::VREDOR:   exec.valuop = vdec_pkg::VALU_OR;
            vdec_pkg::VREDXOR:  exec.valuop = vdec_pkg::VALU_XOR;
            vdec_pkg::VREDMIN:  exec.valuop = vdec_pkg::VALU_MIN;
            vdec_pkg::VREDMAX:  exec.valuop = vdec_pkg::VALU_MAX;
            vdec_pkg::VREDMINU: begin
                exec.valuop      = vdec_pkg::VALU_MIN;
                exec.vopunsigned = 1'b1;
            end
            vdec_pkg::VREDMAXU: begin
                exec.valuop      = vdec_pkg::VALU_MAX;
                exec.vopunsigned = 1'b1;
            end
            vdec_pkg::VMANDN, vdec_pkg::VMAND, vdec_pkg::VMOR, vdec_pkg::VMXOR,
            vdec_pkg::VMORN, vdec_pkg::VMNAND, vdec_pkg::VMNOR, vdec_pkg::VMXNOR: begin
                exec.vfu     = vdec_pkg::VFU_MSK;
                valid        = vm_bit;          // Only the unmasked form is defined
                disable_mask = 1'b1;
                veew_dest    = vdec_pkg::SEW8;
            end
            vdec_pkg::VMUL: exec.vfu = vdec_pkg::VFU_MUL;
            vdec_pkg::VMULH: begin
                exec.vfu    = vdec_pkg::VFU_MUL;
                exec.vmulop = vdec_pkg::VMUL_HI;
            end
            vdec_pkg::VMULHU: begin
                exec.vfu         = vdec_pkg::VFU_MUL;
                exec.vmulop      = vdec_pkg::VMUL_HIU;
                exec.vopunsigned = 1'b1;
            end
            default: valid = 1'b0;
        endcase

        // Mask-logical operation select
        case (vopm)
            vdec_pkg::VMANDN: exec.vmaskop = vdec_pkg::VMSK_ANDN;
            vdec_pkg::VMAND:  exec.vmaskop = vdec_pkg::VMSK_AND;
            vdec_pkg::VMOR:   exec.vmaskop = vdec_pkg::VMSK_OR;
            vdec_pkg::VMXOR:  exec.vmaskop = vdec_pkg::VMSK_XOR;
            vdec_pkg::VMORN:  exec.vmaskop = vdec_pkg::VMSK_ORN;
            vdec_pkg::VMNAND: exec.vmaskop = vdec_pkg::VMSK_NAND;
            vdec_pkg::VMNOR:  exec.vmaskop = vdec_pkg::VMSK_NOR;
            vdec_pkg::VMXNOR: exec.vmaskop = vdec_pkg::VMSK_XNOR;
            default: ;
        endcase
    end

    assign res.exec         = exec;
    assign res.valid        = valid;
    assign res.disable_mask = disable_mask;
    assign res.veew_dest    = veew_dest;

endmodule

// File: hw/vdec_combine.sv
// Decode select and output stage
`timescale 1ns/1ps
`include "vdec_defines.svh"

module vdec_combine (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    output logic              in_ready,
    input  vdec_pkg::vinstr_u in_word,
    vdec_result_if.consumer   opi_res,
    vdec_result_if.consumer   opm_res,
    output vdec_pkg::vsew_t   vsew,
    output logic              out_valid,
    input  logic              out_ready,
    output vdec_pkg::vexec_t  out_exec,
    output logic              out_disable_mask,
    output vdec_pkg::vsew_t   out_veew,
    output logic              out_is_cfg,
    output logic              out_illegal
);

    logic             is_opv;
    logic             cfg_word;
    logic             cfg_ok;
    logic             take;
    vdec_pkg::vsew_t  cfg_sew;
    vdec_pkg::vexec_t nxt_exec;
    logic             nxt_valid;
    logic             nxt_disable_mask;
    vdec_pkg::vsew_t  nxt_veew;

    assign is_opv   = (in_word.arith.opcode == `VDEC_OPCODE_OPV);
    assign cfg_word = is_opv && (in_word.cfg.funct3 == `VDEC_F3_OPCFG);
    // vsetvl/vsetivli and reserved SEW codes are rejected
    assign cfg_ok   = !in_word.cfg.cfg_kind && !in_word.cfg.zimm.vsew[2];
    assign cfg_sew  = vdec_pkg::vsew_t'(in_word.cfg.zimm.vsew[1:0]);

    assign in_ready = !out_valid || out_ready;
    assign take     = in_valid && in_ready;

    always_comb begin
        case (in_word.arith.funct3)
            `VDEC_F3_OPIVV, `VDEC_F3_OPIVI, `VDEC_F3_OPIVX,
            `VDEC_F3_OPFVV, `VDEC_F3_OPFVF: begin
                nxt_exec         = opi_res.exec;   // OPI decoder rejects the OPF codes
                nxt_valid        = opi_res.valid;
                nxt_disable_mask = opi_res.disable_mask;
                nxt_veew         = opi_res.veew_dest;
            end
            `VDEC_F3_OPMVV, `VDEC_F3_OPMVX: begin
                nxt_exec         = opm_res.exec;
                nxt_valid        = opm_res.valid;
                nxt_disable_mask = opm_res.disable_mask;
                nxt_veew         = opm_res.veew_dest;
            end
            default: begin                         // Configuration word
                nxt_exec         = '0;
                nxt_valid        = cfg_word && cfg_ok;
                nxt_disable_mask = 1'b0;
                nxt_veew         = cfg_sew;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_exec         <= '0;
            out_disable_mask <= 1'b0;
            out_veew         <= vdec_pkg::SEW8;
            out_is_cfg       <= 1'b0;
            out_illegal      <= 1'b0;
        end else if (take) begin
            out_exec         <= nxt_exec;
            out_disable_mask <= nxt_disable_mask;
            out_veew         <= nxt_veew;
            out_is_cfg       <= cfg_word;
            out_illegal      <= !is_opv || !nxt_valid;
        end
    end

    // New width is seen by the next word accepted
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vsew <= vdec_pkg::SEW8;
        end else if (take && cfg_word && cfg_ok) begin
            vsew <= cfg_sew;
        end
    end

endmodule

// File: hw/vdec_top.sv
// Vector decode stage top
`timescale 1ns/1ps
`include "vdec_defines.svh"

module vdec_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  logic [`VDEC_ILEN-1:0]   in_word,
    output logic                    in_ready,
    output logic                    out_valid,
    input  logic                    out_ready,
    output vdec_pkg::vfu_t          out_vfu,
    output vdec_pkg::valuop_t       out_valuop,
    output vdec_pkg::vmaskop_t      out_vmaskop,
    output vdec_pkg::vpermop_t      out_vpermop,
    output vdec_pkg::vmulop_t       out_vmulop,
    output logic                    out_unsigned,
    output logic                    out_disable_mask,
    output vdec_pkg::vsew_t         out_veew,
    output logic                    out_is_cfg,
    output logic                    out_illegal
);

    vdec_pkg::vinstr_u word;
    vdec_pkg::vsew_t   vsew;
    vdec_pkg::vexec_t  out_exec;

    vdec_result_if opi_res ();
    vdec_result_if opm_res ();

    assign word = in_word;

    vdec_opi_decode opi_dec (
        .vopi    (vdec_pkg::vopi_t'(word.arith.funct6)),
        .vfunct3 (word.arith.funct3),
        .vm_bit  (word.arith.vm),
        .vsew    (vsew),
        .res     (opi_res.producer)
    );

    vdec_opm_decode opm_dec (
        .vopm   (vdec_pkg::vopm_t'(word.arith.funct6)),
        .vm_bit (word.arith.vm),
        .vsew   (vsew),
        .res    (opm_res.producer)
    );

    vdec_combine combine (
        .clk              (clk),
        .rst_n            (rst_n),
        .in_valid         (in_valid),
        .in_ready         (in_ready),
        .in_word          (word),
        .opi_res          (opi_res.consumer),
        .opm_res          (opm_res.consumer),
        .vsew             (vsew),
        .out_valid        (out_valid),
        .out_ready        (out_ready),
        .out_exec         (out_exec),
        .out_disable_mask (out_disable_mask),
        .out_veew         (out_veew),
        .out_is_cfg       (out_is_cfg),
        .out_illegal      (out_illegal)
    );

    // Flatten the record for the execute stage
    assign out_vfu      = out_exec.vfu;
    assign out_valuop   = out_exec.valuop;
    assign out_vmaskop  = out_exec.vmaskop;
    assign out_vpermop  = out_exec.vpermop;
    assign out_vmulop   = out_exec.vmulop;
    assign out_unsigned = out_exec.vopunsigned;

endmodule

// File: testbench/vdec_tb.sv
// Vector decode testbench
`timescale 1ns/1ps
`include "vdec_defines.svh"

module vdec_tb;

    localparam int FIELDS      = 11;    // Word plus ten expected fields per test
    localparam int MAX_ENTRIES = 512;

    logic                    clk;
    logic                    rst_n;
    logic                    in_valid;
    logic [`VDEC_ILEN-1:0]   in_word;
    logic                    in_ready;
    logic                    out_valid;
    logic                    out_ready;
    vdec_pkg::vfu_t          out_vfu;
    vdec_pkg::valuop_t       out_valuop;
    vdec_pkg::vmaskop_t      out_vmaskop;
    vdec_pkg::vpermop_t      out_vpermop;
    vdec_pkg::vmulop_t       out_vmulop;
    logic                    out_unsigned;
    logic                    out_disable_mask;
    vdec_pkg::vsew_t         out_veew;
    logic                    out_is_cfg;
    logic                    out_illegal;

    logic [31:0] tests_mem [0:MAX_ENTRIES-1];
    logic [31:0] lfsr;
    int          num_tests;
    int          in_idx;
    int          out_idx;
    int          cycles;
    int          limit;

    vdec_top vdec_top_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .in_valid         (in_valid),
        .in_word          (in_word),
        .in_ready         (in_ready),
        .out_valid        (out_valid),
        .out_ready        (out_ready),
        .out_vfu          (out_vfu),
        .out_valuop       (out_valuop),
        .out_vmaskop      (out_vmaskop),
        .out_vpermop      (out_vpermop),
        .out_vmulop       (out_vmulop),
        .out_unsigned     (out_unsigned),
        .out_disable_mask (out_disable_mask),
        .out_veew         (out_veew),
        .out_is_cfg       (out_is_cfg),
        .out_illegal      (out_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;          // 8 ns period
    end

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        lfsr_step = state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    task automatic stop_with_failure();
        $display("Simulation FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_exec(input string name, input vdec_pkg::vexec_t expected,
                              input vdec_pkg::vexec_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns %s expected %h got %h", $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_sew(input string name, input vdec_pkg::vsew_t expected,
                             input vdec_pkg::vsew_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns %s expected %0d got %0d", $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns %s expected %b got %b", $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic check_record(input int idx);
        int               base;
        vdec_pkg::vexec_t expected;
        vdec_pkg::vexec_t actual;
        base                 = 1 + idx * FIELDS;
        expected.vfu         = vdec_pkg::vfu_t'(tests_mem[base+1][2:0]);
        expected.valuop      = vdec_pkg::valuop_t'(tests_mem[base+2][4:0]);
        expected.vmaskop     = vdec_pkg::vmaskop_t'(tests_mem[base+3][2:0]);
        expected.vpermop     = vdec_pkg::vpermop_t'(tests_mem[base+4][1:0]);
        expected.vmulop      = vdec_pkg::vmulop_t'(tests_mem[base+5][1:0]);
        expected.vopunsigned = tests_mem[base+6][0];
        actual.vfu           = out_vfu;
        actual.valuop        = out_valuop;
        actual.vmaskop       = out_vmaskop;
        actual.vpermop       = out_vpermop;
        actual.vmulop        = out_vmulop;
        actual.vopunsigned   = out_unsigned;
        check_flag($sformatf("out_illegal (test %0d)", idx), tests_mem[base+10][0], out_illegal);
        check_flag($sformatf("out_is_cfg (test %0d)", idx), tests_mem[base+9][0], out_is_cfg);
        if (!tests_mem[base+10][0]) begin   // Control fields of an illegal word carry no meaning
            check_exec($sformatf("out_exec (test %0d)", idx), expected, actual);
            check_flag($sformatf("out_disable_mask (test %0d)", idx),
                       tests_mem[base+7][0], out_disable_mask);
            check_sew($sformatf("out_veew (test %0d)", idx),
                      vdec_pkg::vsew_t'(tests_mem[base+8][1:0]), out_veew);
        end
    endtask

    initial begin
        in_valid  = 1'b0;
        in_word   = '0;
        out_ready = 1'b0;
        rst_n     = 1'b0;
        lfsr      = 32'h8c869f93;
        in_idx    = 0;
        out_idx   = 0;
        cycles    = 0;
        $readmemh("testbench/vdec_tests.txt", tests_mem);
        num_tests = tests_mem[0];
        if (num_tests <= 0 || (1 + num_tests * FIELDS) > MAX_ENTRIES) begin
            $display("The test file gives no usable test count");
            stop_with_failure();
        end
        limit = 20 * num_tests + 50;

        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        while (out_idx < num_tests) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                $display("Timeout after %0d cycles, only %0d of %0d records arrived",
                         limit, out_idx, num_tests);
                stop_with_failure();
            end
            in_valid  = (in_idx < num_tests);
            in_word   = in_valid ? tests_mem[1 + in_idx * FIELDS] : '0;
            out_ready = lfsr[0];        // One LFSR bit per cycle of back-pressure
            lfsr      = lfsr_step(lfsr);
            #2;                         // Settled values that the next rising edge sees
            // A single register stage holds at most one accepted word
            check_flag("out_valid", in_idx != out_idx, out_valid);
            check_flag("in_ready", (in_idx == out_idx) || out_ready, in_ready);
            if (out_valid && out_ready) begin
                check_record(out_idx);
                out_idx++;
            end
            if (in_valid && in_ready) begin
                in_idx++;
            end
        end

        // No record may follow the last expected one
        repeat (3) begin
            @(negedge clk);
            in_valid  = 1'b0;
            out_ready = 1'b1;
            #2;
            check_flag("out_valid after last record", 1'b0, out_valid);
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: compile.f
+incdir+include
hw/vdec_pkg.sv
hw/vdec_result_if.sv
hw/vdec_opi_decode.sv
hw/vdec_opm_decode.sv
hw/vdec_combine.sv
hw/vdec_top.sv
testbench/vdec_tb.sv

// File: Bender.yml
package:
  name: vdec

export_include_dirs:
  - include

sources:
  - files:
      - hw/vdec_pkg.sv
      - hw/vdec_result_if.sv
      - hw/vdec_opi_decode.sv
      - hw/vdec_opm_decode.sv
      - hw/vdec_combine.sv
      - hw/vdec_top.sv
  - target: test
    files:
      - testbench/vdec_tb.sv

// File: testbench/vdec_tests.txt
// First value is the test count, then per line: word vfu aluop maskop permop mulop
// unsigned disable_mask veew is_cfg illegal (hex), fields of illegal words are zero
1c
022081d7 0 00 0 0 0 0 0 0 0 0  // vadd.vv at SEW8
122081d7 0 0b 0 0 0 1 0 0 0 0  // vminu.vv
3220b1d7 1 00 0 1 0 0 0 0 0 0  // vrgather.vi
a220c1d7 0 16 0 0 0 1 0 0 0 0  // vsrl.vx
0100f1d7 0 00 0 0 0 0 0 2 1 0  // vsetvli e32
022081d7 0 00 0 0 0 0 0 2 0 0  // vadd.vv at SEW32
622081d7 0 10 0 0 0 0 0 0 0 0  // vmseq.vv
6a20c1d7 0 12 0 0 0 1 0 0 0 0  // vmsltu.vx
462081d7 0 05 0 0 0 0 1 0 0 0  // vmadc.vv, vm 1
442081d7 0 06 0 0 0 0 1 0 0 0  // vmadc.vvm, vm 0
4c2081d7 0 08 0 0 0 0 1 0 0 0  // vmsbc.vvm, vm 0
402081d7 0 03 0 0 0 0 1 2 0 0  // vadc.vvm
5c2081d7 0 09 0 0 0 0 1 2 0 0  // vmerge.vvm
5e2081d7 0 0a 0 0 0 0 1 2 0 0  // vmv.v.v
0220a1d7 2 00 0 0 0 0 0 2 0 0  // vredsum.vs
1a20a1d7 2 0c 0 0 0 1 0 2 0 0  // vredmaxu.vs
6620a1d7 3 00 0 0 0 0 1 0 0 0  // vmand.mm
7e20a1d7 3 00 7 0 0 0 1 0 0 0  // vmxnor.mm
7020a1d7 0 00 0 0 0 0 0 0 0 1  // vmorn.mm with vm 0
9620e1d7 4 00 0 0 0 0 0 2 0 0  // vmul.vx
9220a1d7 4 00 0 0 2 1 0 2 0 0  // vmulhu.vv
be2081d7 0 00 0 0 0 0 0 0 0 1  // vnclip.wv
222081d7 0 00 0 0 0 0 0 0 0 1  // undefined funct6
022091d7 0 00 0 0 0 0 0 0 0 1  // OPFVV funct3
0220d1d7 0 00 0 0 0 0 0 0 0 1  // OPFVF funct3
022081b3 0 00 0 0 0 0 0 0 0 1  // opcode not OP-V
0080f1d7 0 00 0 0 0 0 0 1 1 0  // vsetvli e16
0a20c1d7 0 01 0 0 0 0 0 1 0 0  // vsub.vx at SEW16
